// ==== hw/cvxif_pkg.sv ====
// CV-X-IF subsystem package
// Opcodes, function codes, exception codes and the shared enums

`default_nettype none

package cvxif_pkg;

  // Custom-0 major opcode used by every coprocessor instruction
  localparam logic [6:0] OPCODE_CUSTOM0 = 7'b0001011;

  // funct7 must be zero for all supported operations
  localparam logic [6:0] FUNCT7_COPRO = 7'b0000000;

  // Width of instruction words on the issue channel
  localparam int unsigned InstrW = 32;

  // Width of the exception code on the result channel
  localparam int unsigned ExcCodeW = 6;

  // Operation select, the values match funct3
  typedef enum logic [1:0] {
    OP_ADD  = 2'd0,
    OP_XOR  = 2'd1,
    OP_MADD = 2'd2,
    OP_CHK  = 2'd3
  } copro_op_e;

  // RISC-V privilege levels, H mode is not supported
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_lvl_e;

  // Illegal instruction cause reported by the core side
  localparam logic [ExcCodeW-1:0] EXC_ILLEGAL_INSTR = 6'd2;

  // Coprocessor exception for CCHK outside machine mode
  localparam logic [ExcCodeW-1:0] EXC_PRIV_FAULT = 6'd24;

  // Cycles from issue transfer to CMADD result
  localparam int unsigned MADD_LATENCY = 3;

endpackage

`default_nettype wire

// ==== hw/cvxif_if.sv ====
// CV-X-IF interface between the core-side unit and the coprocessor
// Carries the combined issue/commit channel and the result channel

`timescale 1ns/1ps
`default_nettype none

interface cvxif_if #(
  parameter int unsigned XLEN        = 32,
  parameter int unsigned NumRs       = 3,
  parameter int unsigned TransIdBits = 4
);

  // Issue and commit, driven by the core
  logic                              issue_valid;
  logic [cvxif_pkg::InstrW-1:0]      instr;
  cvxif_pkg::priv_lvl_e              mode;
  logic [TransIdBits-1:0]            id;
  logic [XLEN-1:0]                   rs [NumRs];
  logic [NumRs-1:0]                  rs_valid;
  logic                              commit_valid;
  logic [TransIdBits-1:0]            commit_id;

  // Issue response, driven by the coprocessor
  logic                              issue_ready;
  logic                              accept;
  logic                              writeback;

  // Result channel
  logic                              result_valid;
  logic                              result_ready;
  logic [TransIdBits-1:0]            result_id;
  logic [XLEN-1:0]                   result_data;
  logic                              result_we;
  logic                              result_exc;
  logic [cvxif_pkg::ExcCodeW-1:0]    result_exccode;

  modport core (
    output issue_valid, instr, mode, id, rs, rs_valid, commit_valid, commit_id,
    output result_ready,
    input  issue_ready, accept, writeback,
    input  result_valid, result_id, result_data, result_we, result_exc, result_exccode
  );

  modport copro (
    input  issue_valid, instr, mode, id, rs, rs_valid, commit_valid, commit_id,
    input  result_ready,
    output issue_ready, accept, writeback,
    output result_valid, result_id, result_data, result_we, result_exc, result_exccode
  );

endinterface

`default_nettype wire

// ==== hw/cvxif_fu.sv ====
// Core-side CV-X-IF functional unit
// Issues and commits offloaded instructions and reports rejected ones as illegal

`timescale 1ns/1ps
`default_nettype none

module cvxif_fu #(
  parameter int unsigned XLEN        = 32,
  parameter int unsigned NumRs       = 3,
  parameter int unsigned TransIdBits = 4
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic                         x_valid_i,
  input  wire logic [cvxif_pkg::InstrW-1:0] x_instr_i,
  input  cvxif_pkg::priv_lvl_e              x_priv_i,
  input  wire logic [TransIdBits-1:0]       x_trans_id_i,
  input  wire logic [XLEN-1:0]              x_rs1_i,
  input  wire logic [XLEN-1:0]              x_rs2_i,
  input  wire logic [XLEN-1:0]              x_rs3_i,
  output logic                              x_ready_o,
  output logic                              x_valid_o,
  output logic [TransIdBits-1:0]            x_trans_id_o,
  output logic [XLEN-1:0]                   x_result_o,
  output logic                              x_we_o,
  output logic                              x_exc_valid_o,
  output logic [XLEN-1:0]                   x_exc_cause_o,
  output logic [XLEN-1:0]                   x_exc_tval_o,
  cvxif_if.core                             cvxif_o
);

  logic                         illegal_d, illegal_q;
  logic [TransIdBits-1:0]       illegal_id_d, illegal_id_q;
  logic [cvxif_pkg::InstrW-1:0] illegal_instr_d, illegal_instr_q;
  logic                         rejected;

  // No new issue while an illegal report is still waiting for the port
  assign cvxif_o.issue_valid  = x_valid_i & ~illegal_q;
  assign cvxif_o.instr        = x_instr_i;
  assign cvxif_o.mode         = x_priv_i;
  assign cvxif_o.id           = x_trans_id_i;
  assign cvxif_o.rs[0]        = x_rs1_i;
  assign cvxif_o.rs[1]        = x_rs2_i;
  assign cvxif_o.rs_valid     = '1;
  assign cvxif_o.commit_valid = cvxif_o.issue_valid;
  assign cvxif_o.commit_id    = x_trans_id_i;
  assign cvxif_o.result_ready = 1'b1;

  if (NumRs == 3) begin : gen_rs3
    assign cvxif_o.rs[2] = x_rs3_i;
  end

  assign x_ready_o = cvxif_o.issue_ready & ~illegal_q;

  assign rejected = cvxif_o.issue_valid & cvxif_o.issue_ready & ~cvxif_o.accept;

  always_comb begin
    illegal_d       = illegal_q;
    illegal_id_d    = illegal_id_q;
    illegal_instr_d = illegal_instr_q;
    if (rejected) begin
      illegal_d       = 1'b1;
      illegal_id_d    = x_trans_id_i;
      illegal_instr_d = x_instr_i;
    end

    // Coprocessor result has priority on the output port
    x_valid_o     = cvxif_o.result_valid;
    x_trans_id_o  = cvxif_o.result_valid ? cvxif_o.result_id : '0;
    x_result_o    = cvxif_o.result_valid ? cvxif_o.result_data : '0;
    x_we_o        = cvxif_o.result_valid & cvxif_o.result_we;
    x_exc_valid_o = cvxif_o.result_valid & cvxif_o.result_exc;
    x_exc_cause_o = '0;
    if (cvxif_o.result_valid) begin
      x_exc_cause_o = XLEN'(cvxif_o.result_exccode);
    end
    x_exc_tval_o  = '0;

    // Free slot, so the illegal report goes out now
    if (illegal_d && !cvxif_o.result_valid) begin
      x_valid_o     = 1'b1;
      x_trans_id_o  = illegal_id_d;
      x_result_o    = '0;
      x_we_o        = 1'b0;
      x_exc_valid_o = 1'b1;
      x_exc_cause_o = XLEN'(cvxif_pkg::EXC_ILLEGAL_INSTR);
      x_exc_tval_o  = XLEN'(illegal_instr_d);
      illegal_d     = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q <= 1'b0;
    end else begin
      illegal_q <= illegal_d;
    end
  end

  // ID and instruction word of the pending rejected transfer
  always_ff @(posedge clk_i) begin
    illegal_id_q    <= illegal_id_d;
    illegal_instr_q <= illegal_instr_d;
  end

endmodule

`default_nettype wire

// ==== hw/copro_decoder.sv ====
// Coprocessor instruction decoder
// Decides accept, operation, writeback and privilege fault for custom-0 words

`timescale 1ns/1ps
`default_nettype none

module copro_decoder #(
  parameter int unsigned NumRs = 3
) (
  input  wire logic [cvxif_pkg::InstrW-1:0] instr_i,
  input  cvxif_pkg::priv_lvl_e              mode_i,
  output logic                              accept_o,
  output cvxif_pkg::copro_op_e              op_o,
  output logic                              we_o,
  output logic                              priv_fault_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       enc_ok;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Only funct3 0 to 3 are defined
  assign enc_ok = (opcode == cvxif_pkg::OPCODE_CUSTOM0) &&
                  (funct7 == cvxif_pkg::FUNCT7_COPRO) &&
                  !funct3[2];

  assign op_o = cvxif_pkg::copro_op_e'(funct3[1:0]);

  always_comb begin
    accept_o     = enc_ok;
    priv_fault_o = 1'b0;

    // Multiply-add needs the third source operand
    if (op_o == cvxif_pkg::OP_MADD && NumRs != 3) begin
      accept_o = 1'b0;
    end

    if (accept_o && op_o == cvxif_pkg::OP_CHK && mode_i != cvxif_pkg::PRIV_M) begin
      priv_fault_o = 1'b1;
    end

    // A faulting CCHK never writes the register file
    we_o = accept_o & ~priv_fault_o;
  end

endmodule

`default_nettype wire

// ==== hw/copro_exec_unit.sv ====
// Coprocessor execution unit
// Single-cycle ADD/XOR/CHK and a multi-cycle multiply-add with registered results

`timescale 1ns/1ps
`default_nettype none

module copro_exec_unit #(
  parameter int unsigned XLEN        = 32,
  parameter int unsigned NumRs       = 3,
  parameter int unsigned TransIdBits = 4
) (
  input  wire logic           clk_i,
  input  wire logic           rst_ni,
  input  cvxif_pkg::copro_op_e op_i,
  input  wire logic           we_i,
  input  wire logic           priv_fault_i,
  input  wire logic           accept_i,
  cvxif_if.copro              cvxif_i
);

  localparam int unsigned CntW = $clog2(cvxif_pkg::MADD_LATENCY);

  logic [CntW-1:0]                  cnt_q;
  logic                             busy;
  logic                             res_valid_q;
  logic                             fire;
  logic                             commit_ok;
  logic [XLEN-1:0]                  addend;
  logic [XLEN-1:0]                  madd_res;
  logic [TransIdBits-1:0]           res_id_q;
  logic [XLEN-1:0]                  res_data_q;
  logic                             res_we_q;
  logic                             res_exc_q;
  logic [cvxif_pkg::ExcCodeW-1:0]   res_exccode_q;

  if (NumRs == 3) begin : gen_addend
    assign addend = cvxif_i.rs[2];
  end else begin : gen_no_addend
    assign addend = '0;
  end

  // Truncated to XLEN by the assignment width
  assign madd_res = cvxif_i.rs[0] * cvxif_i.rs[1] + addend;

  assign busy = (cnt_q != '0);

  // Stall while CMADD runs or while a result has not been taken
  assign cvxif_i.issue_ready = ~busy & ~(res_valid_q & ~cvxif_i.result_ready);
  assign cvxif_i.accept      = accept_i;
  assign cvxif_i.writeback   = we_i;

  // Issue and commit arrive together for the same ID
  assign commit_ok = cvxif_i.commit_valid && (cvxif_i.commit_id == cvxif_i.id);
  assign fire      = cvxif_i.issue_valid & cvxif_i.issue_ready & accept_i & commit_ok;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q       <= '0;
      res_valid_q <= 1'b0;
    end else begin
      if (res_valid_q && cvxif_i.result_ready) begin
        res_valid_q <= 1'b0;
      end
      if (fire && op_i == cvxif_pkg::OP_MADD) begin
        cnt_q <= CntW'(cvxif_pkg::MADD_LATENCY - 1);
      end else if (busy) begin
        cnt_q <= cnt_q - 1'b1;
      end
      // Last busy cycle of CMADD, or a single-cycle op just issued
      if (cnt_q == CntW'(1)) begin
        res_valid_q <= 1'b1;
      end
      if (fire && op_i != cvxif_pkg::OP_MADD) begin
        res_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      res_id_q      <= cvxif_i.id;
      res_we_q      <= we_i;
      res_exc_q     <= 1'b0;
      res_exccode_q <= '0;
      unique case (op_i)
        cvxif_pkg::OP_ADD:  res_data_q <= cvxif_i.rs[0] + cvxif_i.rs[1];
        cvxif_pkg::OP_XOR:  res_data_q <= cvxif_i.rs[0] ^ cvxif_i.rs[1];
        cvxif_pkg::OP_MADD: res_data_q <= madd_res;
        cvxif_pkg::OP_CHK: begin
          if (priv_fault_i) begin
            res_data_q    <= '0;
            res_exc_q     <= 1'b1;
            res_exccode_q <= cvxif_pkg::EXC_PRIV_FAULT;
          end else begin
            res_data_q <= cvxif_i.rs[0];
          end
        end
        default: res_data_q <= '0;
      endcase
    end
  end

  assign cvxif_i.result_valid   = res_valid_q;
  assign cvxif_i.result_id      = res_id_q;
  assign cvxif_i.result_data    = res_data_q;
  assign cvxif_i.result_we      = res_we_q;
  assign cvxif_i.result_exc     = res_exc_q;
  assign cvxif_i.result_exccode = res_exccode_q;

endmodule

`default_nettype wire

// ==== hw/cvxif_subsys.sv ====
// CV-X-IF subsystem top level
// Core-side functional unit linked to a custom-0 coprocessor

`timescale 1ns/1ps
`default_nettype none

module cvxif_subsys #(
  parameter int unsigned XLEN        = 32,
  parameter int unsigned NumRs       = 3,
  parameter int unsigned TransIdBits = 4
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic                         x_valid_i,
  input  wire logic [cvxif_pkg::InstrW-1:0] x_instr_i,
  input  cvxif_pkg::priv_lvl_e              x_priv_i,
  input  wire logic [TransIdBits-1:0]       x_trans_id_i,
  input  wire logic [XLEN-1:0]              x_rs1_i,
  input  wire logic [XLEN-1:0]              x_rs2_i,
  input  wire logic [XLEN-1:0]              x_rs3_i,
  output logic                              x_ready_o,
  output logic                              x_valid_o,
  output logic [TransIdBits-1:0]            x_trans_id_o,
  output logic [XLEN-1:0]                   x_result_o,
  output logic                              x_we_o,
  output logic                              x_exc_valid_o,
  output logic [XLEN-1:0]                   x_exc_cause_o,
  output logic [XLEN-1:0]                   x_exc_tval_o
);

  cvxif_pkg::copro_op_e dec_op;
  logic                 dec_accept;
  logic                 dec_we;
  logic                 dec_priv_fault;

  cvxif_if #(
    .XLEN        (XLEN),
    .NumRs       (NumRs),
    .TransIdBits (TransIdBits)
  ) cvxif ();

  cvxif_fu #(
    .XLEN        (XLEN),
    .NumRs       (NumRs),
    .TransIdBits (TransIdBits)
  ) i_cvxif_fu (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .x_valid_i     (x_valid_i),
    .x_instr_i     (x_instr_i),
    .x_priv_i      (x_priv_i),
    .x_trans_id_i  (x_trans_id_i),
    .x_rs1_i       (x_rs1_i),
    .x_rs2_i       (x_rs2_i),
    .x_rs3_i       (x_rs3_i),
    .x_ready_o     (x_ready_o),
    .x_valid_o     (x_valid_o),
    .x_trans_id_o  (x_trans_id_o),
    .x_result_o    (x_result_o),
    .x_we_o        (x_we_o),
    .x_exc_valid_o (x_exc_valid_o),
    .x_exc_cause_o (x_exc_cause_o),
    .x_exc_tval_o  (x_exc_tval_o),
    .cvxif_o       (cvxif.core)
  );

  // Decode straight off the issue channel
  copro_decoder #(
    .NumRs (NumRs)
  ) i_copro_decoder (
    .instr_i      (cvxif.instr),
    .mode_i       (cvxif.mode),
    .accept_o     (dec_accept),
    .op_o         (dec_op),
    .we_o         (dec_we),
    .priv_fault_o (dec_priv_fault)
  );

  copro_exec_unit #(
    .XLEN        (XLEN),
    .NumRs       (NumRs),
    .TransIdBits (TransIdBits)
  ) i_copro_exec_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .op_i         (dec_op),
    .we_i         (dec_we),
    .priv_fault_i (dec_priv_fault),
    .accept_i     (dec_accept),
    .cvxif_i      (cvxif.copro)
  );

endmodule

`default_nettype wire

// ==== dv/cvxif_subsys_chk.sv ====
// Protocol assertions for the CV-X-IF subsystem top level
// Bound into the top level by the testbench

`timescale 1ns/1ps
`default_nettype none

module cvxif_subsys_chk (
  input wire logic        clk_i,
  input wire logic        rst_ni,
  input wire logic        x_valid_i,
  input wire logic [31:0] x_instr_i,
  input wire logic        x_ready_o,
  input wire logic        x_valid_o,
  input wire logic        x_we_o,
  input wire logic        x_exc_valid_o
);

  logic madd_xfer;

  // Accepted CMADD handed over on the top-level issue port
  assign madd_xfer = x_valid_i && x_ready_o &&
                     (x_instr_i[6:0] == cvxif_pkg::OPCODE_CUSTOM0) &&
                     (x_instr_i[31:25] == 7'd0) && (x_instr_i[14:12] == 3'd2);

  a_no_valid_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !x_valid_o)
    else $error("x_valid_o high while reset is asserted");

  a_madd_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    madd_xfer |=> !x_ready_o ##1 !x_ready_o)
    else $error("x_ready_o high while CMADD is busy");

  a_exc_has_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    x_exc_valid_o |-> x_valid_o)
    else $error("x_exc_valid_o without x_valid_o");

  a_no_we_on_exc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(x_we_o && x_exc_valid_o))
    else $error("x_we_o and x_exc_valid_o high together");

endmodule

`default_nettype wire

// ==== dv/tb_cvxif_subsys.sv ====
// Testbench for the CV-X-IF subsystem
// Directed and random issue traffic checked against a reference model

`timescale 1ns/1ps
`default_nettype none

module tb_cvxif_subsys;

  localparam int unsigned XLEN          = 32;
  localparam int unsigned NumRs         = 3;
  localparam int unsigned TransIdBits   = 4;
  localparam int          NumRandom     = 200;
  localparam int          NumTxn        = 27 + NumRandom;
  localparam int          TimeoutCycles = NumTxn * 8 + 100;
  localparam int          MaddCycles    = 3;
  localparam logic [6:0]  OpcCustom0    = 7'b0001011;
  localparam logic [31:0] CauseIllegal  = 32'd2;
  localparam logic [31:0] CausePriv     = 32'd24;

  typedef struct {
    logic [TransIdBits-1:0] id;
    logic [XLEN-1:0]        data;
    logic                   we;
    logic                   exc;
    logic [XLEN-1:0]        cause;
    logic [XLEN-1:0]        tval;
    int                     due;
  } exp_t;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   x_valid_i;
  logic [31:0]            x_instr_i;
  cvxif_pkg::priv_lvl_e   x_priv_i;
  logic [TransIdBits-1:0] x_trans_id_i;
  logic [XLEN-1:0]        x_rs1_i;
  logic [XLEN-1:0]        x_rs2_i;
  logic [XLEN-1:0]        x_rs3_i;
  logic                   x_ready_o;
  logic                   x_valid_o;
  logic [TransIdBits-1:0] x_trans_id_o;
  logic [XLEN-1:0]        x_result_o;
  logic                   x_we_o;
  logic                   x_exc_valid_o;
  logic [XLEN-1:0]        x_exc_cause_o;
  logic [XLEN-1:0]        x_exc_tval_o;

  exp_t        exp_q[$];
  logic [31:0] lcg_state = 32'he8097304;
  int          cycle_cnt = 0;
  int          last_copro_due = -1;
  int          txn_cnt = 0;
  int          err_cnt = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  cvxif_subsys #(
    .XLEN        (XLEN),
    .NumRs       (NumRs),
    .TransIdBits (TransIdBits)
  ) i_dut (
    .clk_i, .rst_ni, .x_valid_i, .x_instr_i, .x_priv_i, .x_trans_id_i,
    .x_rs1_i, .x_rs2_i, .x_rs3_i, .x_ready_o, .x_valid_o, .x_trans_id_o,
    .x_result_o, .x_we_o, .x_exc_valid_o, .x_exc_cause_o, .x_exc_tval_o
  );

  bind cvxif_subsys cvxif_subsys_chk i_chk (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .x_valid_i     (x_valid_i),
    .x_instr_i     (x_instr_i),
    .x_ready_o     (x_ready_o),
    .x_valid_o     (x_valid_o),
    .x_we_o        (x_we_o),
    .x_exc_valid_o (x_exc_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, %0d results still outstanding",
               cycle_cnt, exp_q.size());
      $display("Test failures found");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Register fields are random, they do not affect the result
  function automatic logic [31:0] encode(input logic [6:0] funct7, input logic [2:0] funct3,
                                         input logic [6:0] opcode);
    logic [31:0] r;
    r = next_random();
    return {funct7, r[20:16], r[25:21], funct3, r[30:26], opcode};
  endfunction

  // Roughly one in five words is an illegal encoding
  function automatic logic [31:0] random_instr();
    logic [31:0] r;
    logic [6:0]  opc;
    r = next_random();
    if (r[31:16] % 16'd10 >= 16'd2) begin
      return encode(7'd0, {1'b0, r[9:8]}, OpcCustom0);
    end else if (r[7:6] == 2'd0) begin
      opc = r[14:8];
      if (opc == OpcCustom0) begin
        opc = 7'b0110011;
      end
      return encode(7'd0, 3'd0, opc);
    end else if (r[7:6] == 2'd1) begin
      return encode(r[14:8] | 7'h01, {1'b0, r[9:8]}, OpcCustom0);
    end
    return encode(7'd0, {1'b1, r[9:8]}, OpcCustom0);
  endfunction

  function automatic logic [1:0] random_priv();
    logic [31:0] r;
    r = next_random();
    case (r[31:30])
      2'd0:    return 2'b00;
      2'd1:    return 2'b01;
      default: return 2'b11;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      err_cnt++;
    end
  endtask

  // Reference model, called in the cycle of the issue transfer
  task automatic predict_and_queue(input logic [31:0] instr, input logic [1:0] priv,
                                   input logic [TransIdBits-1:0] id,
                                   input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] rs2,
                                   input logic [XLEN-1:0] rs3);
    exp_t       e;
    logic       legal;
    logic [2:0] f3;
    f3    = instr[14:12];
    legal = (instr[6:0] == OpcCustom0) && (instr[31:25] == 7'd0) && !f3[2];
    if (NumRs == 2 && f3 == 3'd2) begin
      legal = 1'b0;
    end
    e.id    = id;
    e.data  = '0;
    e.we    = 1'b0;
    e.exc   = 1'b0;
    e.cause = '0;
    e.tval  = '0;
    e.due   = cycle_cnt + 1;
    if (!legal) begin
      e.exc   = 1'b1;
      e.cause = CauseIllegal;
      e.tval  = instr;
      // Waits one cycle when a coprocessor result owns the port
      e.due   = (last_copro_due == cycle_cnt) ? cycle_cnt + 1 : cycle_cnt;
    end else begin
      e.we = 1'b1;
      case (f3)
        3'd0: e.data = rs1 + rs2;
        3'd1: e.data = rs1 ^ rs2;
        3'd2: begin
          e.data = rs1 * rs2 + rs3;
          e.due  = cycle_cnt + MaddCycles;
        end
        default: begin
          if (priv == 2'b11) begin
            e.data = rs1;
          end else begin
            e.we    = 1'b0;
            e.exc   = 1'b1;
            e.cause = CausePriv;
          end
        end
      endcase
      last_copro_due = e.due;
    end
    exp_q.push_back(e);
  endtask

  // Called 10 ns after a rising edge, returns at the same point after the transfer
  task automatic issue_instr(input logic [31:0] instr, input logic [1:0] priv);
    x_valid_i    = 1'b1;
    x_instr_i    = instr;
    x_priv_i     = cvxif_pkg::priv_lvl_e'(priv);
    x_trans_id_i = txn_cnt[TransIdBits-1:0];
    x_rs1_i      = next_random();
    x_rs2_i      = next_random();
    x_rs3_i      = next_random();
    @(negedge clk_i);
    while (!x_ready_o) begin
      @(negedge clk_i);
    end
    predict_and_queue(instr, priv, x_trans_id_i, x_rs1_i, x_rs2_i, x_rs3_i);
    txn_cnt++;
    @(posedge clk_i);
    #10;
    x_valid_i = 1'b0;
  endtask

  always @(negedge clk_i) begin
    exp_t e;
    #1;
    if (rst_ni && x_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("Result for ID 0x%0h arrived with no transaction outstanding", x_trans_id_o);
        err_cnt++;
      end else begin
        e = exp_q.pop_front();
        check_value("x_trans_id_o", e.id, x_trans_id_o);
        check_value("x_result_o", e.data, x_result_o);
        check_value("x_we_o", e.we, x_we_o);
        check_value("x_exc_valid_o", e.exc, x_exc_valid_o);
        check_value("x_exc_cause_o", e.cause, x_exc_cause_o);
        check_value("x_exc_tval_o", e.tval, x_exc_tval_o);
        check_value("arrival cycle", e.due, cycle_cnt);
      end
    end
  end

  task automatic drain_and_report(input string name, input int errs_at_start);
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #10;
    tests_run++;
    if (err_cnt != errs_at_start) begin
      tests_failed++;
      $display("Test %s: FAILED with %0d errors", name, err_cnt - errs_at_start);
    end else begin
      $display("Test %s: ok", name);
    end
  endtask

  initial begin
    int errs;
    x_valid_i    = 1'b0;
    x_instr_i    = '0;
    x_priv_i     = cvxif_pkg::PRIV_M;
    x_trans_id_i = '0;
    x_rs1_i      = '0;
    x_rs2_i      = '0;
    x_rs3_i      = '0;
    rst_ni       = 1'b0;
    repeat (8) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;

    errs = err_cnt;
    @(negedge clk_i);
    check_value("x_valid_o", 1'b0, x_valid_o);
    check_value("x_ready_o", 1'b1, x_ready_o);
    @(posedge clk_i);
    #10;
    for (int i = 0; i < 8; i++) begin
      issue_instr(encode(7'd0, 3'(i % 2), OpcCustom0), 2'b11);
    end
    drain_and_report("reset_add_xor", errs);

    errs = err_cnt;
    for (int i = 0; i < 4; i++) begin
      issue_instr(encode(7'd0, 3'd2, OpcCustom0), random_priv());
      // Both busy cycles of the multiply-add
      repeat (2) begin
        @(negedge clk_i);
        check_value("x_ready_o", 1'b0, x_ready_o);
      end
      @(posedge clk_i);
      #10;
    end
    drain_and_report("madd", errs);

    errs = err_cnt;
    issue_instr(encode(7'd0, 3'd0, 7'b0110011), 2'b11);
    issue_instr(encode(7'h20, 3'd0, OpcCustom0), 2'b11);
    for (int f3 = 4; f3 < 8; f3++) begin
      issue_instr(encode(7'd0, 3'(f3), OpcCustom0), 2'b11);
    end
    drain_and_report("illegal", errs);

    errs = err_cnt;
    issue_instr(encode(7'd0, 3'd3, OpcCustom0), 2'b00);
    issue_instr(encode(7'd0, 3'd3, OpcCustom0), 2'b01);
    issue_instr(encode(7'd0, 3'd3, OpcCustom0), 2'b11);
    drain_and_report("chk_priv", errs);

    // Rejected word right behind a single-cycle op, so its report is deferred
    errs = err_cnt;
    for (int i = 0; i < 3; i++) begin
      issue_instr(encode(7'd0, 3'd0, OpcCustom0), 2'b11);
      issue_instr(encode(7'd0, 3'd5, OpcCustom0), 2'b11);
    end
    drain_and_report("back_to_back", errs);

    errs = err_cnt;
    for (int i = 0; i < NumRandom; i++) begin
      issue_instr(random_instr(), random_priv());
    end
    drain_and_report("random", errs);

    $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
             err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
hw/cvxif_pkg.sv
hw/cvxif_if.sv
hw/cvxif_fu.sv
hw/copro_decoder.sv
hw/copro_exec_unit.sv
hw/cvxif_subsys.sv
dv/cvxif_subsys_chk.sv
dv/tb_cvxif_subsys.sv

// ==== Makefile ====
SIM        ?= verilator
TOP        := tb_cvxif_subsys
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := All tests passed!

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
